// File: Makefile
TOP := tb_i2c_master

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f vlog.f --top-module i2c_master_top

clean:
	rm -rf obj_dir sim.log

// File: logic/i2c_line_io.sv
// Open-drain pad side of the I2C master, registers the line enables and synchronizes SDA
`timescale 1ns/1ns

module i2c_line_io (
  input  logic cr_intf,
  input  logic rst_n,
  // Pull-low requests from the controller
  input  logic scl_low,
  input  logic sda_low,
  // SDA level seen at the pad
  input  logic sda_in,
  // Pad enables, high pulls the line low
  output logic scl_oe,
  output logic sda_oe,
  // SDA level in the clock domain
  output logic sda_sync
);

  logic sda_meta;

  // Enables come straight from flops so the pads never glitch
  // Reset releases both lines
  always_ff @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      scl_oe <= 1'b0;
      sda_oe <= 1'b0;
    end
    else
    begin
      scl_oe <= scl_low;
      sda_oe <= sda_low;
    end
  end

  // Two-flop synchronizer
  // Reset to the idle level of the pulled-up line
  always_ff @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      sda_meta <= 1'b1;
      sda_sync <= 1'b1;
    end
    else
    begin
      sda_meta <= sda_in;
      sda_sync <= sda_meta;
    end
  end

endmodule

// File: logic/i2c_macros.svh
// Widths, register offsets and reset values of the I2C master, included by i2c_pkg and the RTL
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// Wishbone port widths
`define I2C_WB_DATA_W   16
`define I2C_WB_ADR_W    2

// Register word offsets
`define I2C_REG_STATUS  2'd0
`define I2C_REG_ADDR    2'd1
`define I2C_REG_DATA    2'd2
`define I2C_REG_CLKDIV  2'd3

// Byte framing on the two-wire bus
`define I2C_BYTE_W      8
`define I2C_DATA_BYTES  2
// Address byte plus the data bytes
`define I2C_XFER_BITS   (`I2C_BYTE_W * (`I2C_DATA_BYTES + 1))

// Phase timer divider, slowest setting out of reset
`define I2C_CLKDIV_W    8
`define I2C_CLKDIV_RST  8'hFF

`endif

// File: logic/i2c_master_top.sv
// Top of the write-only I2C master, Wishbone registers in and open-drain SCL/SDA enables out
`timescale 1ns/1ns

module i2c_master_top (
  input  logic              cr_intf,
  input  logic              rst_n,
  // Wishbone classic slave
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  i2c_pkg::wb_adr_t  wb_adr,
  input  i2c_pkg::wb_data_t wb_dat_w,
  output i2c_pkg::wb_data_t wb_dat_r,
  output logic              wb_ack,
  // Two-wire bus pads
  output logic              scl_oe,
  output logic              sda_oe,
  input  logic              sda_in
);

  import i2c_pkg::*;

  // Register block to controller
  logic       start_req;
  slv_addr_t  slv_addr;
  xfer_data_t xfer_data;
  clk_div_t   clk_div;

  // Controller status
  logic       busy;
  logic       nack;

  // Controller to line interface and back
  logic       scl_low;
  logic       sda_low;
  logic       sda_sync;

  i2c_wb_regs i2c_wb_regs_i (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .busy      (busy),
    .nack      (nack),
    .start_req (start_req),
    .slv_addr  (slv_addr),
    .xfer_data (xfer_data),
    .clk_div   (clk_div)
  );

  i2c_xfer_ctrl i2c_xfer_ctrl_i (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .start_req (start_req),
    .slv_addr  (slv_addr),
    .xfer_data (xfer_data),
    .clk_div   (clk_div),
    .sda_sync  (sda_sync),
    .busy      (busy),
    .nack      (nack),
    .scl_low   (scl_low),
    .sda_low   (sda_low)
  );

  i2c_line_io i2c_line_io_i (
    .cr_intf   (cr_intf),
    .rst_n     (rst_n),
    .scl_low   (scl_low),
    .sda_low   (sda_low),
    .sda_in    (sda_in),
    .scl_oe    (scl_oe),
    .sda_oe    (sda_oe),
    .sda_sync  (sda_sync)
  );

endmodule

// File: logic/i2c_pkg.sv
// Types shared by the I2C master RTL and its testbench, pulled in with a wildcard import
`include "i2c_macros.svh"

package i2c_pkg;

  // Wishbone register port
  typedef logic [`I2C_WB_DATA_W-1:0] wb_data_t;
  typedef logic [`I2C_WB_ADR_W-1:0]  wb_adr_t;

  // Slave address byte, 7-bit address and R/W in bit 0
  typedef logic [`I2C_BYTE_W-1:0] slv_addr_t;

  // Data word sent MSB first after the address byte
  typedef logic [`I2C_DATA_BYTES*`I2C_BYTE_W-1:0] xfer_data_t;

  // Last count of the phase timer
  typedef logic [`I2C_CLKDIV_W-1:0] clk_div_t;

  // Bit position in the whole stream, has to reach I2C_XFER_BITS
  typedef logic [$clog2(`I2C_XFER_BITS + 1)-1:0] bit_cnt_t;

  // Transfer controller states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    START = 3'd1,
    SHIFT = 3'd2,
    ACK   = 3'd3,
    STOP  = 3'd4
  } xfer_state_e;

endpackage

// File: logic/i2c_wb_regs.sv
// Wishbone classic register block of the I2C master, holds the transfer setup and starts transfers
`timescale 1ns/1ns
`include "i2c_macros.svh"

module i2c_wb_regs (
  input  logic                cr_intf,
  input  logic                rst_n,
  // Wishbone classic slave
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  i2c_pkg::wb_adr_t    wb_adr,
  input  i2c_pkg::wb_data_t   wb_dat_w,
  output i2c_pkg::wb_data_t   wb_dat_r,
  output logic                wb_ack,
  // Status from the transfer controller
  input  logic                busy,
  input  logic                nack,
  // Transfer setup towards the controller
  output logic                start_req,
  output i2c_pkg::slv_addr_t  slv_addr,
  output i2c_pkg::xfer_data_t xfer_data,
  output i2c_pkg::clk_div_t   clk_div
);

  import i2c_pkg::*;

  logic     wb_hit;
  logic     wr_hit;
  wb_data_t rd_word;

  // Active cycle not acked yet
  // Blocking on wb_ack keeps a held strobe from getting a second ack
  assign wb_hit = wb_cyc & wb_stb & ~wb_ack;
  assign wr_hit = wb_hit & wb_we;

  // Ack and start pulse, both one clock wide
  always_ff @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      wb_ack    <= 1'b0;
      start_req <= 1'b0;
    end
    else
    begin
      wb_ack    <= wb_hit;
      // Any write to status starts a transfer, the data is ignored
      start_req <= wr_hit && (wb_adr == `I2C_REG_STATUS);
    end
  end

  // Setup registers, updated on the same edge that raises the ack
  always_ff @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      slv_addr  <= '0;
      xfer_data <= '0;
      clk_div   <= `I2C_CLKDIV_RST;
    end
    else
    begin
      if (wr_hit && (wb_adr == `I2C_REG_ADDR))
        slv_addr <= wb_dat_w[$bits(slv_addr_t)-1:0];
      if (wr_hit && (wb_adr == `I2C_REG_DATA))
        xfer_data <= wb_dat_w[$bits(xfer_data_t)-1:0];
      if (wr_hit && (wb_adr == `I2C_REG_CLKDIV))
        clk_div <= wb_dat_w[$bits(clk_div_t)-1:0];
    end
  end

  // Read mux, upper bits stay zero
  always_comb
  begin
    rd_word = '0;
    case (wb_adr)
      `I2C_REG_STATUS:
      begin
        rd_word[0] = busy;
        rd_word[1] = nack;
      end
      `I2C_REG_ADDR:
        rd_word[$bits(slv_addr_t)-1:0] = slv_addr;
      `I2C_REG_DATA:
        rd_word[$bits(xfer_data_t)-1:0] = xfer_data;
      `I2C_REG_CLKDIV:
        rd_word[$bits(clk_div_t)-1:0] = clk_div;
      default:
        rd_word = '0;
    endcase
  end

  // Read data registered together with the ack
  always_ff @(posedge cr_intf)
  begin
    if (wb_hit && !wb_we)
      wb_dat_r <= rd_word;
  end

endmodule

// File: logic/i2c_xfer_ctrl.sv
// I2C write transfer controller, sequences START, address, two data bytes, acks and STOP
`timescale 1ns/1ns
`include "i2c_macros.svh"

module i2c_xfer_ctrl (
  input  logic                cr_intf,
  input  logic                rst_n,
  // Setup from the register block
  input  logic                start_req,
  input  i2c_pkg::slv_addr_t  slv_addr,
  input  i2c_pkg::xfer_data_t xfer_data,
  input  i2c_pkg::clk_div_t   clk_div,
  // Synchronized SDA level from the line interface
  input  logic                sda_sync,
  // Status back to the register block
  output logic                busy,
  output logic                nack,
  // Pull-low requests towards the line interface
  output logic                scl_low,
  output logic                sda_low
);

  import i2c_pkg::*;

  localparam int SHIFT_W   = `I2C_XFER_BITS;
  localparam int BIT_IDX_W = $clog2(`I2C_BYTE_W);
  // One extra bit so clk_div+1 never wraps
  localparam int TICK_W    = $bits(clk_div_t) + 1;

  xfer_state_e        state;
  xfer_state_e        state_nxt;

  clk_div_t           phase_cnt;
  logic [TICK_W-1:0]  cnt_ext;
  logic [TICK_W-1:0]  phase_len;
  logic [TICK_W-1:0]  quarter_pt;
  logic [TICK_W-1:0]  half_pt;
  logic [TICK_W-1:0]  three_q_pt;
  logic               phase_end;
  logic               scl_hi_win;

  logic               start_ok;
  logic               byte_end;
  logic               last_byte;
  logic               ack_tick;
  logic               ack_fail;

  bit_cnt_t           bit_cnt;
  logic [SHIFT_W-1:0] shift_q;

  // Phase is clk_div+1 clocks long, split into quarters
  assign phase_len  = {1'b0, clk_div} + 1'b1;
  assign quarter_pt = phase_len >> 2;
  assign half_pt    = phase_len >> 1;
  assign three_q_pt = quarter_pt + half_pt;
  assign cnt_ext    = {1'b0, phase_cnt};

  // Greater-or-equal so a divider lowered mid-phase still wraps
  assign phase_end  = (phase_cnt >= clk_div);

  // SCL high over the middle half of a bit or ack phase
  assign scl_hi_win = (cnt_ext >= quarter_pt) && (cnt_ext < three_q_pt);

  // Start is only taken from IDLE
  assign start_ok   = (state == IDLE) && start_req;

  // Eighth bit of a byte finishing
  assign byte_end   = phase_end && (bit_cnt[BIT_IDX_W-1:0] == BIT_IDX_W'(`I2C_BYTE_W - 1));

  // All bytes out, the current ack is the last one
  assign last_byte  = (bit_cnt == bit_cnt_t'(SHIFT_W));

  // Ack sample point
  // Later than mid-phase by the pad register and the two sync flops
  assign ack_tick   = (state == ACK) && (cnt_ext == three_q_pt);

  // Sample can land on the wrap clock with the smallest divider
  assign ack_fail   = nack | (ack_tick & sda_sync);

  assign busy       = (state != IDLE);

  // Next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (start_req)
          state_nxt = START;
      end
      START:
      begin
        if (phase_end)
          state_nxt = SHIFT;
      end
      SHIFT:
      begin
        if (byte_end)
          state_nxt = ACK;
      end
      ACK:
      begin
        // A NACK ends the transfer right here
        if (phase_end)
          state_nxt = (ack_fail || last_byte) ? STOP : SHIFT;
      end
      STOP:
      begin
        if (phase_end)
          state_nxt = IDLE;
      end
      default:
        state_nxt = IDLE;
    endcase
  end

  // State, phase timer, bit counter and sticky NACK
  always_ff @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      phase_cnt <= '0;
      bit_cnt   <= '0;
      nack      <= 1'b0;
    end
    else
    begin
      state <= state_nxt;

      // Timer parked at zero while idle
      if ((state == IDLE) || phase_end)
        phase_cnt <= '0;
      else
        phase_cnt <= phase_cnt + 1'b1;

      if (start_ok)
        bit_cnt <= '0;
      else if ((state == SHIFT) && phase_end)
        bit_cnt <= bit_cnt + 1'b1;

      // Cleared by an accepted start, set by SDA high at the ack sample
      if (start_ok)
        nack <= 1'b0;
      else if (ack_tick && sda_sync)
        nack <= 1'b1;
    end
  end

  // Address and data latched at start, MSB leaves first
  always_ff @(posedge cr_intf)
  begin
    if (start_ok)
      shift_q <= {slv_addr, xfer_data};
    else if ((state == SHIFT) && phase_end)
      shift_q <= shift_q << 1;
  end

  // Line requests, SDA only moves at a phase boundary
  always_comb
  begin
    scl_low = 1'b0;
    sda_low = 1'b0;
    case (state)
      START:
      begin
        // SDA drops with SCL high, SCL follows at mid-phase
        sda_low = 1'b1;
        scl_low = (cnt_ext >= half_pt);
      end
      SHIFT:
      begin
        scl_low = ~scl_hi_win;
        sda_low = ~shift_q[SHIFT_W-1];
      end
      ACK:
      begin
        // SDA released for the slave
        scl_low = ~scl_hi_win;
      end
      STOP:
      begin
        // SCL up at the first quarter, SDA up at mid-phase
        scl_low = (cnt_ext < quarter_pt);
        sda_low = (cnt_ext < half_pt);
      end
      default:
      begin
        scl_low = 1'b0;
        sda_low = 1'b0;
      end
    endcase
  end

endmodule

// File: tb/i2c_codec_model.sv
// Behavioral I2C codec slave for the testbench, acks one device address and records the transfer
`timescale 1ns/1ns
`include "i2c_macros.svh"

module i2c_codec_model (
  input  logic                cr_intf,
  input  logic                rst_n,
  // Resolved bus levels
  input  logic                scl,
  input  logic                sda,
  // High pulls SDA low in an ack slot
  output logic                sda_pull,
  // Record of the last transfer, cleared at START
  output i2c_pkg::slv_addr_t  addr_byte,
  output i2c_pkg::xfer_data_t data_word,
  output int                  byte_count,
  // Running totals and the last SCL period in clocks
  output int                  start_count,
  output int                  stop_count,
  output int                  scl_period
);

  import i2c_pkg::*;

  localparam logic [`I2C_BYTE_W-1:0] DEV_ADDR = 8'h34;

  logic                   scl_q;
  logic                   sda_q;
  logic                   in_xfer;
  logic                   addressed;
  logic                   ack_slot;
  logic                   first_byte;
  int                     bit_idx;
  logic [`I2C_BYTE_W-1:0] rx_byte;
  int                     clk_cnt;
  int                     last_rise;

  // Bus sampled every clock, edges found against the previous sample
  always @(posedge cr_intf)
  begin
    if (!rst_n)
    begin
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      sda_pull    <= 1'b0;
      in_xfer     <= 1'b0;
      addressed   <= 1'b0;
      ack_slot    <= 1'b0;
      first_byte  <= 1'b0;
      bit_idx     <= 0;
      rx_byte     <= '0;
      clk_cnt     <= 0;
      last_rise   <= 0;
      addr_byte   <= '0;
      data_word   <= '0;
      byte_count  <= 0;
      start_count <= 0;
      stop_count  <= 0;
      scl_period  <= 0;
    end
    else
    begin
      scl_q   <= scl;
      sda_q   <= sda;
      clk_cnt <= clk_cnt + 1;
      if (scl_q && scl && sda_q && !sda)
      begin
        // START, SDA falls while SCL is high
        start_count <= start_count + 1;
        in_xfer     <= 1'b1;
        first_byte  <= 1'b1;
        addressed   <= 1'b0;
        ack_slot    <= 1'b0;
        bit_idx     <= 0;
        addr_byte   <= '0;
        data_word   <= '0;
        byte_count  <= 0;
      end
      else if (scl_q && scl && !sda_q && sda)
      begin
        // STOP, SDA rises while SCL is high
        stop_count <= stop_count + 1;
        in_xfer    <= 1'b0;
        sda_pull   <= 1'b0;
      end
      else if (in_xfer && !scl_q && scl)
      begin
        // SCL rising, SDA is valid
        if (!ack_slot)
        begin
          rx_byte <= {rx_byte[`I2C_BYTE_W-2:0], sda};
          bit_idx <= bit_idx + 1;
          // Period between two data bits of one byte
          if (!first_byte && (bit_idx != 0))
            scl_period <= clk_cnt - last_rise;
        end
        last_rise <= clk_cnt;
      end
      else if (in_xfer && scl_q && !scl)
      begin
        if (ack_slot)
        begin
          // Ack clock over, let SDA go
          ack_slot <= 1'b0;
          sda_pull <= 1'b0;
          bit_idx  <= 0;
        end
        else if (bit_idx == `I2C_BYTE_W)
        begin
          ack_slot   <= 1'b1;
          first_byte <= 1'b0;
          if (first_byte)
          begin
            addr_byte <= rx_byte;
            addressed <= (rx_byte == DEV_ADDR);
            sda_pull  <= (rx_byte == DEV_ADDR);
          end
          else if (addressed)
          begin
            // MSB byte arrives first
            data_word  <= {data_word[$bits(xfer_data_t)-`I2C_BYTE_W-1:0], rx_byte};
            byte_count <= byte_count + 1;
            sda_pull   <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: tb/tb_i2c_master.sv
// Testbench for the I2C master, runs a table of codec transfers through the Wishbone port
`timescale 1ns/1ns
`include "i2c_macros.svh"

module tb_i2c_master;

  import i2c_pkg::*;

  localparam int N_ROWS      = 6;
  localparam int CLK_NS      = 20;
  // Rows x phases x longest phase x clock period x margin
  localparam int WATCHDOG_NS = N_ROWS * 29 * 16 * CLK_NS * 4;

  logic       cr_intf;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_adr_t    wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  logic       scl_oe;
  logic       sda_oe;
  logic       sda_pull;
  logic       scl;
  logic       sda;

  slv_addr_t  addr_byte;
  xfer_data_t data_word;
  int         byte_count;
  int         start_count;
  int         stop_count;
  int         scl_period;

  // Stimulus table, one column per field
  slv_addr_t  tbl_addr [N_ROWS]    = '{8'h34, 8'h34, 8'h52, 8'h34, 8'h20, 8'h34};
  xfer_data_t tbl_data [N_ROWS]    = '{16'hA55A, 16'h1234, 16'hBEEF, 16'h0F0F, 16'hFFFF, 16'h8001};
  clk_div_t   tbl_div [N_ROWS]     = '{8'd3, 8'd7, 8'd7, 8'd15, 8'd3, 8'd15};
  logic       tbl_nack [N_ROWS]    = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
  logic       tbl_busy_wr [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

  integer     seed;
  wb_data_t   rd;
  int         starts_before;
  int         stops_before;
  slv_addr_t  new_addr;
  xfer_data_t new_data;

  // Open-drain bus with pull-ups, any enable pulls a line low
  assign scl = ~scl_oe;
  assign sda = ~(sda_oe | sda_pull);

  initial
  begin
    cr_intf = 1'b0;
    forever
      #(CLK_NS / 2) cr_intf = ~cr_intf;
  end

  i2c_master_top i2c_master_top_i (
    .cr_intf  (cr_intf),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .scl_oe   (scl_oe),
    .sda_oe   (sda_oe),
    .sda_in   (sda)
  );

  i2c_codec_model i2c_codec_model_i (
    .cr_intf     (cr_intf),
    .rst_n       (rst_n),
    .scl         (scl),
    .sda         (sda),
    .sda_pull    (sda_pull),
    .addr_byte   (addr_byte),
    .data_word   (data_word),
    .byte_count  (byte_count),
    .start_count (start_count),
    .stop_count  (stop_count),
    .scl_period  (scl_period)
  );

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Waits for the ack, ends the cycle, then expects the ack gone
  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    @(posedge cr_intf);
    #2;
    while (!wb_ack && (waited < 16))
    begin
      waited++;
      @(posedge cr_intf);
      #2;
    end
    if (!wb_ack)
    begin
      $display("Wishbone %s got no ack within 16 clocks", what);
      $display("TESTS FAILED");
      $fatal(1, "bus hang");
    end
    else
    begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(posedge cr_intf);
      #2;
      check_eq(wb_ack, 1'b0, {what, " acked more than once"});
    end
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
    @(posedge cr_intf);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wait_ack("write");
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
    @(posedge cr_intf);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack("read");
    // Read data stays registered after the ack
    dat = wb_dat_r;
  endtask

  // Polls status until busy drops, returns the last status word
  task automatic wait_idle(output wb_data_t st);
    wb_read(`I2C_REG_STATUS, st);
    while (st[0])
      wb_read(`I2C_REG_STATUS, st);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed     = 18054;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (16) @(posedge cr_intf);
    #2;
    rst_n = 1'b1;

    // Reset state
    check_eq(scl, 1'b1, "SCL released after reset");
    check_eq(sda, 1'b1, "SDA released after reset");
    check_eq(wb_ack, 1'b0, "no ack after reset");
    wb_read(`I2C_REG_STATUS, rd);
    check_eq(rd, 16'h0000, "status after reset");
    wb_read(`I2C_REG_ADDR, rd);
    check_eq(rd, 16'h0000, "address register after reset");
    wb_read(`I2C_REG_DATA, rd);
    check_eq(rd, 16'h0000, "data register after reset");
    wb_read(`I2C_REG_CLKDIV, rd);
    check_eq(rd, `I2C_CLKDIV_RST, "divider after reset");

    for (int i = 0; i < N_ROWS; i++)
    begin
      // Upper bits written as ones must read back as zero
      wb_write(`I2C_REG_ADDR, {8'hA5, tbl_addr[i]});
      wb_write(`I2C_REG_DATA, tbl_data[i]);
      wb_write(`I2C_REG_CLKDIV, {8'h5A, tbl_div[i]});
      wb_read(`I2C_REG_ADDR, rd);
      check_eq(rd, {8'h00, tbl_addr[i]}, "address register read-back");
      wb_read(`I2C_REG_DATA, rd);
      check_eq(rd, tbl_data[i], "data register read-back");
      wb_read(`I2C_REG_CLKDIV, rd);
      check_eq(rd, {8'h00, tbl_div[i]}, "divider read-back");

      starts_before = start_count;
      stops_before  = stop_count;
      wb_write(`I2C_REG_STATUS, 16'h0000);
      // Busy up and any old nack cleared
      wb_read(`I2C_REG_STATUS, rd);
      check_eq(rd, 16'h0001, "status right after start");

      if (tbl_busy_wr[i])
      begin
        new_addr = slv_addr_t'($random(seed));
        new_data = xfer_data_t'($random(seed));
        // New setup first, so a wrongly taken second start would send it
        wb_write(`I2C_REG_ADDR, {8'h00, new_addr});
        wb_write(`I2C_REG_DATA, new_data);
        wb_write(`I2C_REG_STATUS, 16'h0000);
      end

      wait_idle(rd);
      check_eq(rd[1], tbl_nack[i], "nack flag after transfer");
      check_eq(start_count - starts_before, 1, "one START per transfer");
      check_eq(stop_count - stops_before, 1, "one STOP per transfer");
      check_eq(addr_byte, tbl_addr[i], "address byte on the bus");
      if (!tbl_nack[i])
      begin
        check_eq(byte_count, `I2C_DATA_BYTES, "data bytes received");
        check_eq(data_word, tbl_data[i], "data word on the bus");
        check_eq(scl_period, tbl_div[i] + 1, "SCL period in clocks");
      end
      else
      begin
        check_eq(byte_count, 0, "no data bytes after NACK");
      end

      if (tbl_busy_wr[i])
      begin
        wb_read(`I2C_REG_ADDR, rd);
        check_eq(rd, {8'h00, new_addr}, "address rewritten during busy");
        wb_read(`I2C_REG_DATA, rd);
        check_eq(rd, new_data, "data rewritten during busy");
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/i2c_pkg.sv
logic/i2c_wb_regs.sv
logic/i2c_xfer_ctrl.sv
logic/i2c_line_io.sv
logic/i2c_master_top.sv
tb/i2c_codec_model.sv
tb/tb_i2c_master.sv
